// File: compile.f
+incdir+verilog
verilog/abr_params_pkg.sv
verilog/decompress_defines_pkg.sv
verilog/decompress_ingest.sv
verilog/decompress_lane.sv
verilog/decompress_pack.sv
verilog/decompress_ctrl.sv
verilog/decompress_top.sv
bench/tb_clock_gen.sv
bench/decompress_tb.sv

// File: Bender.yml
package:
  name: decompress

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/abr_params_pkg.sv
      - verilog/decompress_defines_pkg.sv
      - verilog/decompress_ingest.sv
      - verilog/decompress_lane.sv
      - verilog/decompress_pack.sv
      - verilog/decompress_ctrl.sv
      - verilog/decompress_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_clock_gen.sv
      - bench/decompress_tb.sv

// File: bench/decompress_tb.sv
// ----------------------------------------------------------
// Table-driven testbench for the decompression unit
// Acts as producer and as the memory, stops at the first error
// Inputs change on the falling edge, outputs are read there too
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "decompress_config.svh"

module decompress_tb;

    import abr_params_pkg::*;
    import decompress_defines_pkg::*;

    localparam int WORDS_PER_POLY = `MLKEM_N / `COEFFS_PER_WORD;
    localparam int NUM_RUNS       = 6;
    localparam int MEM_WORDS      = 1 << `ABR_MEM_ADDR_WIDTH;

    // One row of the stimulus table describes one whole run
    typedef struct packed {
        decomp_mode_t mode;
        logic [3:0]   depth;
        logic [2:0]   num_poly;
        mem_addr_t    base;
        logic         zeroize_mid;
    } run_entry_t;

    logic         clk;
    logic         reset_n;
    logic         zeroize;
    logic         decompress_enable;
    logic [2:0]   num_poly;
    decomp_mode_t mode;
    mem_addr_t    dest_base_addr;
    logic         in_req;
    comp_word_t   comp_data;
    logic         in_ack;
    mem_wr_t      mem_wr;
    logic         done;

    run_entry_t run_table [0:NUM_RUNS-1];
    comp_word_t sent_words [0:`MAX_NUM_POLY*WORDS_PER_POLY-1];
    // Memory model with a write counter per address
    mem_data_t  mem [0:MEM_WORDS-1];
    int         hits [0:MEM_WORDS-1];

    mem_addr_t run_base;
    int        run_words;
    int        sent_count;
    int        wr_idx;
    int        done_count;
    logic      final_write_prev;
    logic      ack_prev;
    int        cycle_count;
    int        cycle_limit;

    tb_clock_gen clock_gen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    decompress_top decompress_top_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .decompress_enable (decompress_enable),
        .num_poly          (num_poly),
        .mode              (mode),
        .dest_base_addr    (dest_base_addr),
        .in_req            (in_req),
        .comp_data         (comp_data),
        .in_ack            (in_ack),
        .mem_wr            (mem_wr),
        .done              (done)
    );

    task automatic verify(input logic ok, input string what);
        assert (ok) else begin
            $display("** Error at %0t ns: %s", $time, what);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Reference rule: mask to d bits, times q, plus half, shift right by d
    function automatic mem_data_t expected_word(comp_word_t word, int d);
        mem_data_t result;
        int        x;
        for (int f = 0; f < `COEFFS_PER_WORD; f++) begin
            x = int'(word[f*`COMP_FIELD_WIDTH +: `COMP_FIELD_WIDTH]) & ((1 << d) - 1);
            result[f*`COEFF_WIDTH +: `COEFF_WIDTH] = (x * `MLKEM_Q + (1 << (d - 1))) >> d;
        end
        return result;
    endfunction

    // Inputs are driven with nonblocking assignments, so this block sees
    // the values that the DUT sampled on the last rising edge
    always @(negedge clk) begin
        if (reset_n) begin
            verify(!(in_ack && !ack_prev) || in_req, "in_ack rose while in_req was low");
            verify(!(!in_ack && ack_prev) || !in_req || zeroize,
                   "in_ack fell while in_req was still high");
            if (zeroize) begin
                verify(!in_ack && !mem_wr.valid && !done, "outputs not cleared by zeroize");
            end
            if (done) begin
                verify(final_write_prev && done_count == 0,
                       "done pulsed other than once right after the final write");
                done_count++;
            end
            final_write_prev = 1'b0;
            if (mem_wr.valid) begin
                verify(wr_idx < sent_count, "write without a matching handshake");
                verify(mem_wr.addr == run_base + mem_addr_t'(wr_idx),
                       $sformatf("write address %h, expected %h",
                                 mem_wr.addr, run_base + mem_addr_t'(wr_idx)));
                mem[mem_wr.addr] = mem_wr.data;
                hits[mem_wr.addr]++;
                final_write_prev = (wr_idx == run_words - 1);
                wr_idx++;
            end
            ack_prev = in_ack;
        end
    end

    // Ends a run that hangs
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    task automatic wait_for_ack(input logic level);
        do @(negedge clk); while (in_ack !== level);
    endtask

    // Random gap, then one full four-phase handshake
    task automatic send_word();
        comp_word_t word;
        repeat ($urandom_range(3, 0)) @(negedge clk);
        word = comp_word_t'({$urandom, $urandom});
        sent_words[sent_count] = word;
        sent_count++;
        comp_data <= word;
        in_req    <= 1'b1;
        wait_for_ack(1'b1);
        in_req <= 1'b0;
        wait_for_ack(1'b0);
    endtask

    // Zeroize hits while req is still high and the last word sits in the lanes
    // Without it ack would stay up and the word would reach the write port
    task automatic abort_with_zeroize();
        comp_word_t word;
        word = comp_word_t'({$urandom, $urandom});
        sent_words[sent_count] = word;
        sent_count++;
        comp_data <= word;
        in_req    <= 1'b1;
        wait_for_ack(1'b1);
        @(negedge clk);
        zeroize <= 1'b1;
        @(negedge clk);
        zeroize <= 1'b0;
        in_req  <= 1'b0;
        repeat (4) @(negedge clk);
    endtask

    // Every written address must hold the expected word, written once
    task automatic check_memory(input int depth);
        mem_addr_t addr;
        mem_data_t expected;
        for (int i = 0; i < wr_idx; i++) begin
            addr     = run_base + mem_addr_t'(i);
            expected = expected_word(sent_words[i], depth);
            verify(hits[addr] == 1, $sformatf("address %h written %0d times", addr, hits[addr]));
            verify(mem[addr] == expected,
                   $sformatf("data at %h is %h, expected %h", addr, mem[addr], expected));
            hits[addr] = 0;
        end
    endtask

    task automatic run_once(input run_entry_t entry);
        int n_send;
        @(negedge clk);
        run_base   = entry.base;
        run_words  = int'(entry.num_poly) * WORDS_PER_POLY;
        sent_count = 0;
        wr_idx     = 0;
        done_count = 0;
        mode              <= entry.mode;
        num_poly          <= entry.num_poly;
        dest_base_addr    <= entry.base;
        decompress_enable <= 1'b1;
        @(negedge clk);
        decompress_enable <= 1'b0;
        n_send = entry.zeroize_mid ? run_words / 2 : run_words;
        repeat (n_send) send_word();
        if (entry.zeroize_mid) begin
            abort_with_zeroize();
            verify(wr_idx == sent_count - 1, "zeroized run wrote the wrong number of words");
            verify(done_count == 0, "done pulsed in a zeroized run");
        end else begin
            while (done_count == 0) @(negedge clk);
            repeat (3) @(negedge clk);
            verify(done_count == 1, "done did not pulse exactly once");
            verify(wr_idx == run_words && sent_count == run_words,
                   $sformatf("%0d writes for %0d handshakes", wr_idx, sent_count));
        end
        check_memory(entry.depth);
    endtask

    initial begin
        int total_words;
        zeroize           = 1'b0;
        decompress_enable = 1'b0;
        num_poly          = 3'd1;
        mode              = D1;
        dest_base_addr    = '0;
        in_req            = 1'b0;
        comp_data         = '0;
        ack_prev          = 1'b0;
        final_write_prev  = 1'b0;
        cycle_count       = 0;
        run_base          = '0;
        run_words         = 0;
        sent_count        = 0;
        wr_idx            = 0;
        done_count        = 0;
        void'($urandom(71));

        // Mode, depth, polynomials, base address, zeroize mid-run
        run_table[0] = '{D1,  4'd1,  3'd1, 15'h0000, 1'b0};
        run_table[1] = '{D4,  4'd4,  3'd2, 15'h0100, 1'b0};
        run_table[2] = '{D5,  4'd5,  3'd3, 15'h1F00, 1'b1};
        run_table[3] = '{D10, 4'd10, 3'd4, 15'h2345, 1'b0};
        run_table[4] = '{D11, 4'd11, 3'd1, 15'h7FC0, 1'b0};
        run_table[5] = '{D1,  4'd1,  3'd3, 15'h4000, 1'b0};

        total_words = 0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            total_words += int'(run_table[r].num_poly) * WORDS_PER_POLY;
        end
        cycle_limit = total_words * 12 + 200;

        while (!reset_n) @(negedge clk);
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_once(run_table[r]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: bench/tb_clock_gen.sv
// ----------------------------------------------------------
// Testbench clock of 10 ns and a synchronous reset
// reset_n is released on a falling edge after 4 cycles
// ----------------------------------------------------------
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is held low over the first rising edges
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;
    end

endmodule

// File: verilog/decompress_top.sv
// ----------------------------------------------------------
// ML-KEM coefficient decompression unit
// A write leaves 3 cycles after req is first seen high
// mode and num_poly must hold until done
// ----------------------------------------------------------
`timescale 1ns/1ns

module decompress_top (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize,
    input  logic                                  decompress_enable,
    input  logic [2:0]                            num_poly,
    input  decompress_defines_pkg::decomp_mode_t  mode,
    input  abr_params_pkg::mem_addr_t             dest_base_addr,
    input  logic                                  in_req,
    input  decompress_defines_pkg::comp_word_t    comp_data,
    output logic                                  in_ack,
    output abr_params_pkg::mem_wr_t               mem_wr,
    output logic                                  done
);

    import abr_params_pkg::*;
    import decompress_defines_pkg::*;

    lane_in_t  lane0_in;
    lane_in_t  lane1_in;
    lane_out_t lane0_out;
    lane_out_t lane1_out;
    mem_addr_t wr_addr;

    // Handshake receiver, splits each word across the lanes
    decompress_ingest ingest_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_req    (in_req),
        .comp_data (comp_data),
        .in_ack    (in_ack),
        .lane0_in  (lane0_in),
        .lane1_in  (lane1_in)
    );

    // Fields 0 and 1
    decompress_lane lane0_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .mode     (mode),
        .lane_in  (lane0_in),
        .lane_out (lane0_out)
    );

    // Fields 2 and 3
    decompress_lane lane1_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .mode     (mode),
        .lane_in  (lane1_in),
        .lane_out (lane1_out)
    );

    // The packer samples the address one cycle before its write,
    // ctrl only advances after that write so the address matches
    decompress_pack pack_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .lane0_out (lane0_out),
        .lane1_out (lane1_out),
        .wr_addr   (wr_addr),
        .mem_wr    (mem_wr)
    );

    decompress_ctrl ctrl_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .decompress_enable (decompress_enable),
        .num_poly          (num_poly),
        .mem_wr_valid      (mem_wr.valid),
        .dest_base_addr    (dest_base_addr),
        .mem_wr_addr       (wr_addr),
        .done              (done)
    );

endmodule

// File: verilog/decompress_ctrl.sv
// ----------------------------------------------------------
// Sequences write addresses over 1 to 4 polynomials from a
// base address, 64 words each, then pulses done once
// Memory writes are never stalled
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "decompress_config.svh"

module decompress_ctrl (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       decompress_enable,
    input  logic [2:0]                 num_poly,
    input  logic                       mem_wr_valid,
    input  abr_params_pkg::mem_addr_t  dest_base_addr,
    output abr_params_pkg::mem_addr_t  mem_wr_addr,
    output logic                       done
);

    import abr_params_pkg::*;

    localparam int WORDS_PER_POLY = `MLKEM_N / `COEFFS_PER_WORD;

    mem_addr_t last_addr;
    logic      active;
    logic      last_wr;

    // Final address of the run, fixed at enable
    always_ff @(posedge clk) begin
        if (decompress_enable) begin
            last_addr <= dest_base_addr + mem_addr_t'(num_poly) * mem_addr_t'(WORDS_PER_POLY)
                         - mem_addr_t'(1);
        end
    end

    // The write in flight carries the current address
    assign last_wr = active && mem_wr_valid && (mem_wr_addr == last_addr);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mem_wr_addr <= '0;
            active      <= 1'b0;
        end else if (zeroize) begin
            mem_wr_addr <= '0;
            active      <= 1'b0;
        end else if (last_wr) begin
            // Run complete, go back to idle
            mem_wr_addr <= '0;
            active      <= 1'b0;
        end else if (decompress_enable) begin
            mem_wr_addr <= dest_base_addr;
            active      <= 1'b1;
        end else if (mem_wr_valid) begin
            mem_wr_addr <= mem_wr_addr + mem_addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            done <= 1'b0;
        end else if (zeroize) begin
            done <= 1'b0;
        end else begin
            done <= last_wr;
        end
    end

    a_num_poly_range : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        decompress_enable |-> (num_poly >= 3'd1) && (num_poly <= `MAX_NUM_POLY)
    );

    // A new run only starts once the packer has gone quiet
    a_enable_not_on_write : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        !(decompress_enable && mem_wr_valid)
    );

endmodule

// File: verilog/decompress_pack.sv
// ----------------------------------------------------------
// Joins both lane results into one memory write
// The address is sampled with the coefficients
// ----------------------------------------------------------
`timescale 1ns/1ns

module decompress_pack (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize,
    input  decompress_defines_pkg::lane_out_t  lane0_out,
    input  decompress_defines_pkg::lane_out_t  lane1_out,
    input  abr_params_pkg::mem_addr_t          wr_addr,
    output abr_params_pkg::mem_wr_t            mem_wr
);

    import abr_params_pkg::*;

    logic      valid_q;
    mem_addr_t addr_q;
    mem_data_t data_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else if (zeroize) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lane0_out.valid & lane1_out.valid;
        end
    end

    // Field order is kept, so coefficient 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (lane0_out.valid) begin
            addr_q <= wr_addr;
            data_q <= {lane1_out.coeff1, lane1_out.coeff0,
                       lane0_out.coeff1, lane0_out.coeff0};
        end
    end

    assign mem_wr = '{valid: valid_q, addr: addr_q, data: data_q};

    // Both lanes are fed from one word, so they run in lockstep
    a_lanes_aligned : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        lane0_out.valid == lane1_out.valid
    );

endmodule

// File: verilog/decompress_lane.sv
// ----------------------------------------------------------
// Decompresses two fields per word with the rounding rule
// (x * q + 2^(d-1)) >> d, registered with one cycle latency
// mode must stay stable while words are in flight
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "decompress_config.svh"

module decompress_lane (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize,
    input  decompress_defines_pkg::decomp_mode_t  mode,
    input  decompress_defines_pkg::lane_in_t      lane_in,
    output decompress_defines_pkg::lane_out_t     lane_out
);

    import decompress_defines_pkg::*;

    logic [3:0] depth;
    logic       valid_q;
    coeff_t     coeff0_q;
    coeff_t     coeff1_q;

    // Maps the mode to the compression depth d
    always_comb begin
        case (mode)
            D1:      depth = 4'd1;
            D4:      depth = 4'd4;
            D5:      depth = 4'd5;
            D10:     depth = 4'd10;
            D11:     depth = 4'd11;
            default: depth = 4'd1;
        endcase
    end

    // Expands one field, the product needs 24 bits at d = 11
    function automatic coeff_t expand(comp_field_t field, logic [3:0] d);
        comp_field_t mask;
        logic [23:0] prod;
        mask = comp_field_t'((12'd1 << d) - 12'd1);
        // Bits above d are ignored, then round to nearest
        prod = 24'(field & mask) * 24'(`MLKEM_Q) + (24'd1 << (d - 4'd1));
        return coeff_t'(prod >> d);
    endfunction

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else if (zeroize) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lane_in.valid;
        end
    end

    // Results are only loaded with a new word
    always_ff @(posedge clk) begin
        if (lane_in.valid) begin
            coeff0_q <= expand(lane_in.field0, depth);
            coeff1_q <= expand(lane_in.field1, depth);
        end
    end

    assign lane_out = '{valid: valid_q, coeff1: coeff1_q, coeff0: coeff0_q};

    // Every word comes out a cycle later, fully reduced below q
    a_lane_result : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        lane_in.valid |=> lane_out.valid && (lane_out.coeff0 < `MLKEM_Q)
                          && (lane_out.coeff1 < `MLKEM_Q)
    );

endmodule

// File: verilog/decompress_ingest.sv
// ----------------------------------------------------------
// Four-phase req/ack receiver for compressed words
// comp_data must hold steady while in_req is high
// One lane valid pulse is produced per handshake
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "decompress_config.svh"

module decompress_ingest (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize,
    input  logic                                in_req,
    input  decompress_defines_pkg::comp_word_t  comp_data,
    output logic                                in_ack,
    output decompress_defines_pkg::lane_in_t    lane0_in,
    output decompress_defines_pkg::lane_in_t    lane1_in
);

    import decompress_defines_pkg::*;

    localparam int FW = `COMP_FIELD_WIDTH;

    ingest_state_t state;
    comp_word_t    word_q;
    logic          lane_valid;

    // IDLE waits for req, ACK lasts one cycle and issues the word,
    // WAIT_REQ_LOW holds ack until the producer releases req
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (zeroize) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (in_req) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    // The producer may already have dropped req here
                    state <= in_req ? WAIT_REQ_LOW : IDLE;
                end
                WAIT_REQ_LOW: begin
                    if (!in_req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The word is taken on the same edge that leaves IDLE
    always_ff @(posedge clk) begin
        if (state == IDLE && in_req) begin
            word_q <= comp_data;
        end
    end

    // Ack is high in every state but IDLE
    assign in_ack = (state != IDLE);

    // ACK is entered once per word, so this is a one-cycle pulse
    assign lane_valid = (state == ACK);

    // Lane 0 takes fields 0 and 1, lane 1 takes fields 2 and 3
    assign lane0_in = '{valid: lane_valid,
                        field1: word_q[1*FW +: FW],
                        field0: word_q[0*FW +: FW]};
    assign lane1_in = '{valid: lane_valid,
                        field1: word_q[3*FW +: FW],
                        field0: word_q[2*FW +: FW]};

    // Ack only rises after the producer has requested
    a_ack_after_req : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        $rose(in_ack) |-> $past(in_req)
    );

endmodule

// File: verilog/decompress_defines_pkg.sv
// ----------------------------------------------------------
// Decompression types: fields, words, lane buses and FSMs
// Only the low d bits of a compressed field carry data
// ----------------------------------------------------------
`include "decompress_config.svh"

package decompress_defines_pkg;

    // One decompressed coefficient, always below q
    typedef logic [`COEFF_WIDTH-1:0] coeff_t;

    // One compressed field at the widest depth
    typedef logic [`COMP_FIELD_WIDTH-1:0] comp_field_t;

    // Four compressed fields, field 0 in the low bits
    typedef logic [`COMP_FIELD_WIDTH*`COEFFS_PER_WORD-1:0] comp_word_t;

    // Compression depth d selected for a run
    typedef enum logic [2:0] {
        D1,
        D4,
        D5,
        D10,
        D11
    } decomp_mode_t;

    // Two fields for one lane, valid is a single-cycle pulse
    typedef struct packed {
        logic        valid;
        comp_field_t field1;
        comp_field_t field0;
    } lane_in_t;

    // Two expanded coefficients from one lane
    typedef struct packed {
        logic   valid;
        coeff_t coeff1;
        coeff_t coeff0;
    } lane_out_t;

    // States of the four-phase receiver
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_REQ_LOW
    } ingest_state_t;

endpackage

// File: verilog/abr_params_pkg.sv
// ----------------------------------------------------------
// Memory-side types shared by the packer, the control block
// and the top level. The write port has no ready signal
// ----------------------------------------------------------
`include "decompress_config.svh"

package abr_params_pkg;

    // Word address into the destination memory
    typedef logic [`ABR_MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // One memory word holds four coefficients
    // Coefficient 0 sits in the low bits
    typedef logic [`COEFF_WIDTH*`COEFFS_PER_WORD-1:0] mem_data_t;

    // Single write request toward the memory
    // The memory accepts it in the cycle that valid is high
    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        mem_data_t data;
    } mem_wr_t;

endpackage

// File: verilog/decompress_config.svh
// ----------------------------------------------------------
// Sizing constants for the ML-KEM decompression unit
// Memory words carry four 12-bit coefficients
// Compressed fields are at most 11 bits wide
// ----------------------------------------------------------
`ifndef DECOMPRESS_CONFIG_SVH
`define DECOMPRESS_CONFIG_SVH

// Coefficients in one polynomial and the ML-KEM modulus
`define MLKEM_N 256
`define MLKEM_Q 3329

// Word address width of the destination memory
`define ABR_MEM_ADDR_WIDTH 15

// One decompressed coefficient is below q, so 12 bits hold it
`define COEFF_WIDTH 12
// Widest compressed field, used at d = 11
`define COMP_FIELD_WIDTH 11

// A run covers at most this many polynomials
`define MAX_NUM_POLY 4
`define COEFFS_PER_WORD 4

`endif
